/* list.f */
design/g729Pkg.sv
design/synFiltPkg.sv
design/basicOps.sv
design/scratchMem.sv
design/synFilt.sv
design/apbHostPort.sv
design/synFiltTop.sv
verification/synFiltTb.sv

/* verification/synFiltTb.sv */
`timescale 1ns/1ps
`default_nettype none

module synFiltTb;

	localparam int order = 10;
	localparam int subLen = 40;
	localparam int apbTimeout = 8;
	localparam int irqTimeout = 5000;
	localparam int runCycles = subLen * (2 * order + 5) + 100;
	localparam longint accHi = 64'sh7FFF_FFFF;
	localparam longint accLo = -64'sh8000_0000;

	// Scratch memory layout in words
	localparam int xBase = 'h100;
	localparam int aBase = 'h040;
	localparam int yBase = 'h200;
	localparam int histBase = 'h300;
	localparam int spareWord = 'h500;

	logic pclk;
	logic rstN;
	logic psel;
	logic penable;
	logic pwrite;
	logic [13:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic irq;

	logic [15:0] lfsr;
	logic signed [15:0] xs [subLen];
	logic signed [15:0] coefs [order+1];
	logic signed [15:0] hist [order+1];
	logic signed [15:0] yExp [subLen];

	synFiltTop #(.order(order), .subLen(subLen)) dut (
		.pclk(pclk), .rstN(rstN), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .irq(irq)
	);

	always #50 pclk = ~pclk;

	////////////////////////////////////////////////////////////
	// Random numbers and reference model
	////////////////////////////////////////////////////////////

	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsrStep(lfsr);
		end
		return v;
	endfunction

	function automatic logic signed [15:0] randSigned(input int n);
		int r;
		r = int'(randBits(n));
		if (r >= (1 << (n - 1)))
			r = r - (1 << n);
		return 16'(r);
	endfunction

	function automatic longint clampAcc(input longint v);
		if (v > accHi)
			return accHi;
		if (v < accLo)
			return accLo;
		return v;
	endfunction

	// Doubled product where only -1 times -1 overflows
	function automatic longint fracMult(input longint a, input longint b);
		if (a == -32768 && b == -32768)
			return accHi;
		return 2 * a * b;
	endfunction

	function automatic logic signed [15:0] refSample(input int n);
		longint accum;
		longint past;
		accum = fracMult(xs[n], coefs[0]);
		for (int t = 1; t <= order; t++)
		begin
			past = (t <= n) ? yExp[n - t] : hist[t - n];
			accum = clampAcc(accum - fracMult(coefs[t], past));
		end
		accum = clampAcc(accum * 8);
		accum = clampAcc(accum + 32768);
		return 16'(accum >>> 16);
	endfunction

	function automatic logic [13:0] windowAddr(input int k);
		return synFiltPkg::memWindow + 14'(k * 4);
	endfunction

	////////////////////////////////////////////////////////////
	// Checking and bus tasks
	////////////////////////////////////////////////////////////

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic expectEqual(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
			abortRun($sformatf("Error: %s = 0x%h, expected 0x%h", name, got, exp));
	endtask

	// Setup and access phases followed by a hold until pready
	task automatic busTransfer(input logic wr, input logic [13:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err,
		output int waits);
		int cnt;
		cnt = 0;
		@(posedge pclk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= wr;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge pclk);
		penable <= 1'b1;
		@(negedge pclk);
		while (!pready && cnt < apbTimeout)
		begin
			cnt++;
			@(negedge pclk);
		end
		assert (pready)
		else
			abortRun("Timeout: pready never rose during an APB transfer");
		rdata = prdata;
		err = pslverr;
		waits = cnt;
		@(posedge pclk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apbWrite(input logic [13:0] addr, input logic [31:0] data,
		output logic err);
		logic [31:0] unused;
		int waits;
		busTransfer(1'b1, addr, data, unused, err, waits);
		expectEqual("write wait cycles", waits, 0);
	endtask

	task automatic apbRead(input logic [13:0] addr, output logic [31:0] data,
		output logic err, output int waits);
		busTransfer(1'b0, addr, 32'd0, data, err, waits);
	endtask

	task automatic writeReg(input logic [13:0] addr, input logic [31:0] data);
		logic err;
		apbWrite(addr, data, err);
		expectEqual("pslverr", err, 0);
	endtask

	task automatic writeWord(input int k, input logic [31:0] data);
		writeReg(windowAddr(k), data);
	endtask

	task automatic readWord(input int k, output logic [31:0] data);
		logic err;
		int waits;
		apbRead(windowAddr(k), data, err, waits);
		expectEqual("pslverr", err, 0);
		expectEqual("read wait cycles", waits, 1);
	endtask

	task automatic waitIrq();
		int cnt;
		cnt = 0;
		@(negedge pclk);
		while (!irq && cnt < irqTimeout)
		begin
			cnt++;
			@(negedge pclk);
		end
		assert (irq)
		else
			abortRun("Timeout: irq never rose after the filter was started");
	endtask

	// Status read must report done and drop irq
	task automatic ackIrq();
		logic [31:0] status;
		logic err;
		int waits;
		apbRead(synFiltPkg::regStatus, status, err, waits);
		expectEqual("status done bit", 32'(status[0]), 1);
		@(negedge pclk);
		expectEqual("irq", 32'(irq), 0);
	endtask

	task automatic loadFilter();
		for (int n = 0; n < subLen; n++)
			writeWord(xBase + n, 32'(xs[n]));
		for (int t = 0; t <= order; t++)
			writeWord(aBase + t, 32'(coefs[t]));
		for (int j = 1; j <= order; j++)
			writeWord(histBase + j, 32'(hist[j]));
		writeReg(synFiltPkg::regXAddr, xBase);
		writeReg(synFiltPkg::regAAddr, aBase);
		writeReg(synFiltPkg::regYAddr, yBase);
		writeReg(synFiltPkg::regMemAddr, histBase);
	endtask

	task automatic runFilter(input logic upd);
		writeReg(synFiltPkg::regCtrl, {30'd0, upd, 1'b1});
		waitIrq();
		ackIrq();
	endtask

	task automatic predictOutputs();
		for (int n = 0; n < subLen; n++)
			yExp[n] = refSample(n);
	endtask

	task automatic compareOutputs();
		logic [31:0] got;
		for (int n = 0; n < subLen; n++)
		begin
			readWord(yBase + n, got);
			expectEqual("y", got, 32'(yExp[n]));
		end
	endtask

	task automatic randomizeData();
		coefs[0] = 16'sd4096;
		for (int t = 1; t <= order; t++)
			coefs[t] = randSigned(10);
		for (int n = 0; n < subLen; n++)
			xs[n] = randSigned(14);
		for (int j = 0; j <= order; j++)
			hist[j] = randSigned(14);
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic checkRegisters();
		logic [13:0] regs [4];
		logic [31:0] vals [4];
		logic [31:0] got;
		logic err;
		int waits;
		regs[0] = synFiltPkg::regXAddr;
		regs[1] = synFiltPkg::regAAddr;
		regs[2] = synFiltPkg::regYAddr;
		regs[3] = synFiltPkg::regMemAddr;
		for (int i = 0; i < 4; i++)
		begin
			vals[i] = randBits(11);
			writeReg(regs[i], vals[i]);
		end
		for (int i = 0; i < 4; i++)
		begin
			apbRead(regs[i], got, err, waits);
			expectEqual("prdata", got, vals[i]);
			expectEqual("pslverr", err, 0);
			expectEqual("read wait cycles", waits, 0);
		end
		apbRead(14'h018, got, err, waits);
		expectEqual("pslverr", err, 1);
		apbWrite(14'h1F00, 32'h1234, err);
		expectEqual("pslverr", err, 1);
	endtask

	task automatic checkMemWindow();
		int k;
		logic [31:0] val;
		logic [31:0] got;
		for (int i = 0; i < 12; i++)
		begin
			k = int'(randBits(11));
			val = 32'(randSigned(16));
			writeWord(k, val);
			readWord(k, got);
			expectEqual("prdata", got, val);
		end
	endtask

	// Unity gain is 4096 in Q12
	task automatic runIdentityFilter();
		randomizeData();
		coefs[0] = 16'sd4096;
		for (int t = 1; t <= order; t++)
			coefs[t] = 16'sd0;
		xs[0] = 16'sh7FFF;
		xs[1] = 16'sh8000;
		xs[2] = 16'sh7FFE;
		xs[3] = 16'sh8001;
		xs[4] = 16'sd0;
		loadFilter();
		runFilter(1'b0);
		for (int n = 0; n < subLen; n++)
			yExp[n] = xs[n];
		compareOutputs();
	endtask

	task automatic runRandomFilter();
		randomizeData();
		loadFilter();
		runFilter(1'b0);
		predictOutputs();
		compareOutputs();
	endtask

	task automatic checkMemUpdate();
		logic [31:0] got;
		randomizeData();
		loadFilter();
		runFilter(1'b0);
		predictOutputs();
		compareOutputs();
		for (int j = 1; j <= order; j++)
		begin
			readWord(histBase + j, got);
			expectEqual("filter memory", got, 32'(hist[j]));
		end
		runFilter(1'b1);
		compareOutputs();
		// Most recent output lands at histBase + 1
		for (int j = 1; j <= order; j++)
		begin
			readWord(histBase + j, got);
			expectEqual("filter memory", got, 32'(yExp[subLen - j]));
		end
	endtask

	task automatic checkBusyProtection();
		logic [31:0] got;
		logic err;
		int waits;
		writeWord(spareWord, 32'h0000_1357);
		writeReg(synFiltPkg::regCtrl, 32'd1);
		apbWrite(windowAddr(spareWord), 32'hDEAD_BEEF, err);
		expectEqual("pslverr", err, 1);
		apbRead(windowAddr(spareWord), got, err, waits);
		expectEqual("pslverr", err, 1);
		expectEqual("read wait cycles", waits, 0);
		// Second start lands mid-run
		apbWrite(synFiltPkg::regCtrl, 32'd1, err);
		expectEqual("pslverr", err, 0);
		waitIrq();
		ackIrq();
		for (int i = 0; i < runCycles; i++)
		begin
			@(negedge pclk);
			assert (!irq)
			else
				abortRun("A start written while busy produced a second interrupt");
		end
		readWord(spareWord, got);
		expectEqual("prdata", got, 32'h0000_1357);
	endtask

	initial
	begin
		lfsr = 16'd41;
		pclk = 1'b0;
		rstN = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (3) @(posedge pclk);
		@(negedge pclk);
		expectEqual("pready", 32'(pready), 0);
		expectEqual("pslverr", 32'(pslverr), 0);
		expectEqual("irq", 32'(irq), 0);
		@(posedge pclk);
		rstN <= 1'b1;
		checkRegisters();
		checkMemWindow();
		runIdentityFilter();
		runRandomFilter();
		checkMemUpdate();
		checkBusyProtection();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* design/synFiltTop.sv */
`timescale 1ns/1ps
`default_nettype none

module synFiltTop #(
	parameter int order = 10,
	parameter int subLen = 40
) (
	input  wire logic        pclk,
	input  wire logic        rstN,
	input  wire logic        psel,
	input  wire logic        penable,
	input  wire logic        pwrite,
	input  wire logic [13:0] paddr,
	input  wire logic [31:0] pwdata,
	output logic [31:0]      prdata,
	output logic             pready,
	output logic             pslverr,
	output logic             irq
);
	localparam int aw = synFiltPkg::addrWidth;

	logic start;
	logic update;
	logic busy;
	logic done;
	logic filtWe;
	logic memWe;
	logic [aw-1:0] xAddr;
	logic [aw-1:0] aAddr;
	logic [aw-1:0] yAddr;
	logic [aw-1:0] memAddr;
	logic [aw-1:0] filtAddr;
	logic [aw-1:0] memAddrOut;
	logic [31:0] filtWData;
	logic [31:0] memWData;
	logic [31:0] memRData;
	g729Pkg::aluOp_e op;
	logic signed [g729Pkg::wordWidth-1:0] opA;
	logic signed [g729Pkg::wordWidth-1:0] opB;
	logic signed [g729Pkg::accWidth-1:0] acc;
	logic signed [g729Pkg::accWidth-1:0] result;

	apbHostPort #(.order(order), .subLen(subLen)) hostPort (
		.pclk(pclk), .rstN(rstN), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .irq(irq), .start(start), .update(update),
		.xAddr(xAddr), .aAddr(aAddr), .yAddr(yAddr), .memAddr(memAddr),
		.busy(busy), .done(done), .filtAddr(filtAddr), .filtWData(filtWData),
		.filtWe(filtWe), .memRData(memRData), .memAddrOut(memAddrOut),
		.memWData(memWData), .memWe(memWe)
	);

	synFilt #(.order(order), .subLen(subLen)) filtCtrl (
		.clk(pclk), .rstN(rstN), .start(start), .update(update),
		.xAddr(xAddr), .aAddr(aAddr), .yAddr(yAddr), .memAddr(memAddr),
		.memRData(memRData), .result(result), .memAddrOut(filtAddr),
		.memWData(filtWData), .memWe(filtWe), .busy(busy), .done(done),
		.op(op), .opA(opA), .opB(opB), .acc(acc)
	);

	basicOps ops (
		.op(op), .opA(opA), .opB(opB), .acc(acc), .result(result)
	);

	scratchMem scratch (
		.clk(pclk), .we(memWe), .addr(memAddrOut), .wdata(memWData), .rdata(memRData)
	);

endmodule

`default_nettype wire

/* design/apbHostPort.sv */
`timescale 1ns/1ps
`default_nettype none

module apbHostPort #(
	parameter int order = 10,
	parameter int subLen = 40
) (
	input  wire logic                             pclk,
	input  wire logic                             rstN,
	input  wire logic                             psel,
	input  wire logic                             penable,
	input  wire logic                             pwrite,
	input  wire logic [13:0]                      paddr,
	input  wire logic [31:0]                      pwdata,
	output logic [31:0]                           prdata,
	output logic                                  pready,
	output logic                                  pslverr,
	output logic                                  irq,
	output logic                                  start,
	output logic                                  update,
	output logic [synFiltPkg::addrWidth-1:0]      xAddr,
	output logic [synFiltPkg::addrWidth-1:0]      aAddr,
	output logic [synFiltPkg::addrWidth-1:0]      yAddr,
	output logic [synFiltPkg::addrWidth-1:0]      memAddr,
	input  wire logic                             busy,
	input  wire logic                             done,
	input  wire logic [synFiltPkg::addrWidth-1:0] filtAddr,
	input  wire logic [31:0]                      filtWData,
	input  wire logic                             filtWe,
	input  wire logic [31:0]                      memRData,
	output logic [synFiltPkg::addrWidth-1:0]      memAddrOut,
	output logic [31:0]                           memWData,
	output logic                                  memWe
);
	localparam int aw = synFiltPkg::addrWidth;

	logic access;
	logic inWindow;
	logic regHit;
	logic windowRead;
	logic waitDone;
	logic hostWe;
	logic regWrite;
	logic statusRead;
	logic doneFlag;
	logic [31:0] regData;

	assign access = psel && penable;
	assign inWindow = paddr >= synFiltPkg::memWindow;

	////////////////////////////////////////////////////////////
	// Register decode
	////////////////////////////////////////////////////////////

	always_comb
	begin
		regHit = 1'b1;
		case (paddr)
			synFiltPkg::regCtrl:    regData = {30'd0, update, 1'b0};
			synFiltPkg::regStatus:  regData = {8'd0, 8'(subLen), 8'(order), 6'd0, busy, irq};
			synFiltPkg::regXAddr:   regData = 32'(xAddr);
			synFiltPkg::regAAddr:   regData = 32'(aAddr);
			synFiltPkg::regYAddr:   regData = 32'(yAddr);
			synFiltPkg::regMemAddr: regData = 32'(memAddr);
			default:
			begin
				regHit = 1'b0;
				regData = '0;
			end
		endcase
	end

	// Writes are dropped while a run is in progress
	assign regWrite = access && pwrite && regHit && !busy;
	assign statusRead = access && !pwrite && paddr == synFiltPkg::regStatus;
	assign windowRead = access && inWindow && !pwrite && !busy;
	assign hostWe = access && pwrite && inWindow && !busy;

	// Window reads wait one cycle for the RAM
	assign pready = access && !(windowRead && !waitDone);
	assign pslverr = access && (inWindow ? busy : !regHit);
	assign prdata = !access ? '0 : (inWindow ? memRData : regData);
	assign irq = doneFlag || done;

	always_ff @(posedge pclk or negedge rstN)
	begin
		if (!rstN)
		begin
			waitDone <= 1'b0;
			start <= 1'b0;
			doneFlag <= 1'b0;
			update <= 1'b0;
			xAddr <= '0;
			aAddr <= '0;
			yAddr <= '0;
			memAddr <= '0;
		end
		else
		begin
			waitDone <= windowRead && !waitDone;
			start <= regWrite && paddr == synFiltPkg::regCtrl && pwdata[0];
			// Status read clears the sticky flag
			if (statusRead)
				doneFlag <= 1'b0;
			else if (done)
				doneFlag <= 1'b1;
			if (regWrite)
			begin
				case (paddr)
					synFiltPkg::regCtrl:    update <= pwdata[1];
					synFiltPkg::regXAddr:   xAddr <= pwdata[aw-1:0];
					synFiltPkg::regAAddr:   aAddr <= pwdata[aw-1:0];
					synFiltPkg::regYAddr:   yAddr <= pwdata[aw-1:0];
					synFiltPkg::regMemAddr: memAddr <= pwdata[aw-1:0];
					default: ;
				endcase
			end
		end
	end

	// Memory port belongs to the controller during a run
	assign memAddrOut = busy ? filtAddr : paddr[aw+1:2];
	assign memWData = busy ? filtWData : pwdata;
	assign memWe = busy ? filtWe : hostWe;

	aStartBusy: assert property (@(posedge pclk) disable iff (!rstN)
		start |=> busy);
	aHostWeIdle: assert property (@(posedge pclk) disable iff (!rstN)
		hostWe |=> !busy);

endmodule

`default_nettype wire

/* design/synFilt.sv */
`timescale 1ns/1ps
`default_nettype none

module synFilt #(
	parameter int order = 10,
	parameter int subLen = 40
) (
	input  wire logic                                clk,
	input  wire logic                                rstN,
	input  wire logic                                start,
	input  wire logic                                update,
	input  wire logic [synFiltPkg::addrWidth-1:0]    xAddr,
	input  wire logic [synFiltPkg::addrWidth-1:0]    aAddr,
	input  wire logic [synFiltPkg::addrWidth-1:0]    yAddr,
	input  wire logic [synFiltPkg::addrWidth-1:0]    memAddr,
	input  wire logic [31:0]                         memRData,
	input  wire logic signed [g729Pkg::accWidth-1:0] result,
	output logic [synFiltPkg::addrWidth-1:0]         memAddrOut,
	output logic [31:0]                              memWData,
	output logic                                     memWe,
	output logic                                     busy,
	output logic                                     done,
	output g729Pkg::aluOp_e                          op,
	output logic signed [g729Pkg::wordWidth-1:0]     opA,
	output logic signed [g729Pkg::wordWidth-1:0]     opB,
	output logic signed [g729Pkg::accWidth-1:0]      acc
);
	localparam int aw = synFiltPkg::addrWidth;
	localparam int ww = g729Pkg::wordWidth;

	synFiltPkg::ctrlState_e state;
	synFiltPkg::ctrlState_e nextState;
	logic [aw-1:0] sampleCnt;
	logic [aw-1:0] tapCnt;
	logic [aw-1:0] pastAddr;
	logic xPhase;
	logic lastTap;
	logic lastSample;
	logic signed [ww-1:0] xReg;
	logic signed [ww-1:0] coefReg;
	logic signed [ww-1:0] yReg;
	logic signed [g729Pkg::accWidth-1:0] accReg;

	assign lastTap = tapCnt == aw'(order);
	assign lastSample = sampleCnt == aw'(subLen - 1);

	// Recent outputs come from this subframe and older ones from the filter memory
	assign pastAddr = (tapCnt <= sampleCnt) ? yAddr + sampleCnt - tapCnt
		: memAddr + tapCnt - sampleCnt;

	////////////////////////////////////////////////////////////
	// Sequencing
	////////////////////////////////////////////////////////////

	always_comb
	begin
		nextState = state;
		case (state)
			synFiltPkg::idle, synFiltPkg::finish:
				nextState = start ? synFiltPkg::loadX : synFiltPkg::idle;
			synFiltPkg::loadX:
				if (xPhase)
					nextState = synFiltPkg::mult;
			synFiltPkg::mult:    nextState = synFiltPkg::loadTap;
			synFiltPkg::loadTap: nextState = synFiltPkg::msu;
			synFiltPkg::msu:     nextState = lastTap ? synFiltPkg::round : synFiltPkg::loadTap;
			synFiltPkg::round:   nextState = synFiltPkg::writeY;
			synFiltPkg::writeY:
				if (!lastSample)
					nextState = synFiltPkg::loadX;
				else if (update)
					nextState = synFiltPkg::updRead;
				else
					nextState = synFiltPkg::finish;
			synFiltPkg::updRead:  nextState = synFiltPkg::updWrite;
			synFiltPkg::updWrite: nextState = lastTap ? synFiltPkg::finish : synFiltPkg::updRead;
			default:              nextState = synFiltPkg::idle;
		endcase
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= synFiltPkg::idle;
			sampleCnt <= '0;
			tapCnt <= '0;
			xPhase <= 1'b0;
		end
		else
		begin
			state <= nextState;
			case (state)
				synFiltPkg::idle, synFiltPkg::finish:
				begin
					sampleCnt <= '0;
					xPhase <= 1'b0;
				end
				synFiltPkg::loadX: xPhase <= !xPhase;
				synFiltPkg::mult:  tapCnt <= aw'(1);
				synFiltPkg::msu:
					if (!lastTap)
						tapCnt <= tapCnt + 1'b1;
				synFiltPkg::writeY:
				begin
					sampleCnt <= sampleCnt + 1'b1;
					tapCnt <= aw'(1);
				end
				synFiltPkg::updWrite: tapCnt <= tapCnt + 1'b1;
				default: ;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////

	// Each register catches the word requested one cycle earlier
	always_ff @(posedge clk)
	begin
		case (state)
			synFiltPkg::loadX:
				if (xPhase)
					xReg <= memRData[ww-1:0];
			synFiltPkg::mult, synFiltPkg::msu: accReg <= result;
			synFiltPkg::loadTap: coefReg <= memRData[ww-1:0];
			synFiltPkg::round:   yReg <= result[ww-1:0];
			default: ;
		endcase
	end

	always_comb
	begin
		case (state)
			synFiltPkg::loadX:    memAddrOut = xPhase ? aAddr : xAddr + sampleCnt;
			synFiltPkg::mult:     memAddrOut = aAddr + aw'(1);
			synFiltPkg::loadTap:  memAddrOut = pastAddr;
			synFiltPkg::msu:      memAddrOut = aAddr + tapCnt + aw'(1);
			synFiltPkg::writeY:   memAddrOut = yAddr + sampleCnt;
			synFiltPkg::updRead:  memAddrOut = yAddr + aw'(subLen) - tapCnt;
			synFiltPkg::updWrite: memAddrOut = memAddr + tapCnt;
			default:              memAddrOut = '0;
		endcase
	end

	always_comb
	begin
		case (state)
			synFiltPkg::msu:   op = g729Pkg::opMsu;
			synFiltPkg::round: op = g729Pkg::opShl3Round;
			default:           op = g729Pkg::opMult;
		endcase
	end

	assign opA = (state == synFiltPkg::msu) ? coefReg : xReg;
	assign opB = memRData[ww-1:0];
	assign acc = accReg;

	// The update copies words that are already sign-extended
	assign memWData = (state == synFiltPkg::updWrite) ? memRData : 32'(yReg);
	assign memWe = state inside {synFiltPkg::writeY, synFiltPkg::updWrite};
	assign busy = !(state inside {synFiltPkg::idle, synFiltPkg::finish});
	assign done = state == synFiltPkg::finish;

	// Writes stay inside the output and filter memory areas
	aWriteInRange: assert property (@(posedge clk) disable iff (!rstN)
		memWe |-> sampleCnt <= aw'(subLen) && tapCnt <= aw'(order));
	aDonePulse: assert property (@(posedge clk) disable iff (!rstN)
		done |=> !done);

endmodule

`default_nettype wire

/* design/scratchMem.sv */
`timescale 1ns/1ps
`default_nettype none

module scratchMem (
	input  wire logic                             clk,
	input  wire logic                             we,
	input  wire logic [synFiltPkg::addrWidth-1:0] addr,
	input  wire logic [31:0]                      wdata,
	output logic [31:0]                           rdata
);
	localparam int depth = 1 << synFiltPkg::addrWidth;

	logic [31:0] mem [depth];

	// A write returns the old word at the same address
	always_ff @(posedge clk)
	begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

/* design/basicOps.sv */
`timescale 1ns/1ps
`default_nettype none

module basicOps (
	input  wire g729Pkg::aluOp_e                      op,
	input  wire logic signed [g729Pkg::wordWidth-1:0] opA,
	input  wire logic signed [g729Pkg::wordWidth-1:0] opB,
	input  wire logic signed [g729Pkg::accWidth-1:0]  acc,
	output logic signed [g729Pkg::accWidth-1:0]       result
);
	localparam int aw = g729Pkg::accWidth;
	localparam int ww = g729Pkg::wordWidth;

	logic signed [aw-1:0] rawProd;
	logic signed [aw-1:0] prod;
	logic signed [aw:0]   diff;
	logic signed [aw-1:0] shifted;
	logic signed [aw:0]   rounded;
	logic signed [aw-1:0] roundSat;

	// Clamp a sum with one guard bit into the accumulator range
	function automatic logic signed [aw-1:0] satAcc(input logic signed [aw:0] v);
		if (v[aw] != v[aw-1])
			return v[aw] ? g729Pkg::minAcc : g729Pkg::maxAcc;
		return v[aw-1:0];
	endfunction

	always_comb
	begin
		// Doubled fractional product
		rawProd = opA * opB;
		if (opA == g729Pkg::minWord && opB == g729Pkg::minWord)
			prod = g729Pkg::maxAcc;
		else
			prod = rawProd <<< 1;

		diff = {acc[aw-1], acc} - {prod[aw-1], prod};

		// Top four bits must agree or the shift overflows
		if (acc[aw-1:aw-4] == {4{acc[aw-1]}})
			shifted = acc <<< 3;
		else
			shifted = acc[aw-1] ? g729Pkg::minAcc : g729Pkg::maxAcc;

		rounded = {shifted[aw-1], shifted} + {1'b0, g729Pkg::roundConst};
		roundSat = satAcc(rounded);

		case (op)
			g729Pkg::opMult:      result = prod;
			g729Pkg::opMsu:       result = satAcc(diff);
			g729Pkg::opShl3Round: result = {{(aw-ww){roundSat[aw-1]}}, roundSat[aw-1:ww]};
			default:              result = acc;
		endcase
	end

endmodule

`default_nettype wire

/* design/synFiltPkg.sv */
`default_nettype none

package synFiltPkg;

	// Controller states
	typedef enum logic [3:0] {
		idle,
		loadX,
		mult,
		loadTap,
		msu,
		round,
		writeY,
		updRead,
		updWrite,
		finish
	} ctrlState_e;

	// APB register byte offsets
	localparam logic [13:0] regCtrl = 14'h000;
	localparam logic [13:0] regStatus = 14'h004;
	localparam logic [13:0] regXAddr = 14'h008;
	localparam logic [13:0] regAAddr = 14'h00C;
	localparam logic [13:0] regYAddr = 14'h010;
	localparam logic [13:0] regMemAddr = 14'h014;

	// Scratch memory window and word address width
	localparam logic [13:0] memWindow = 14'h2000;
	localparam int addrWidth = 11;

endpackage

`default_nettype wire

/* design/g729Pkg.sv */
`default_nettype none

package g729Pkg;

	// Sample and accumulator widths
	localparam int wordWidth = 16;
	localparam int accWidth = 32;

	// Saturation limits
	localparam logic signed [wordWidth-1:0] maxWord = 16'sh7FFF;
	localparam logic signed [wordWidth-1:0] minWord = 16'sh8000;
	localparam logic signed [accWidth-1:0] maxAcc = 32'sh7FFF_FFFF;
	localparam logic signed [accWidth-1:0] minAcc = 32'sh8000_0000;

	// Added before the high half is taken
	localparam logic signed [accWidth-1:0] roundConst = 32'sh0000_8000;

	// Arithmetic opcodes of the basic operators
	typedef enum logic [1:0] {
		opMult,
		opMsu,
		opShl3Round
	} aluOp_e;

endpackage

`default_nettype wire
